// File: common/cnn_pkg.sv
`include "cnn_settings.svh"

package cnn_pkg;

    // Unsigned image pixel or rectified feature value
    typedef logic [`CNN_PIXEL_W-1:0] pixel_t;

    // Kernel tap or bias
    typedef logic signed [`CNN_WEIGHT_W-1:0] weight_t;

    // Sum of 25 products plus the scaled bias
    typedef logic signed [`CNN_ACC_W-1:0] acc_t;

    // Tap index is row * 5 + column
    // Tap 0 is the oldest pixel, at the top left
    typedef pixel_t [`CNN_TAPS-1:0] window_t;

    // Feature map number
    typedef logic [$clog2(`CNN_LANES)-1:0] lane_t;

    // Values 0 to 24 pick a kernel tap, 25 picks the bias
    typedef logic [$clog2(`CNN_TAPS + 1)-1:0] coef_index_t;

endpackage

// File: common/cnn_settings.svh
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// Image and kernel geometry
`define CNN_IMG_SIZE  12
`define CNN_KERNEL    5
`define CNN_TAPS      (`CNN_KERNEL * `CNN_KERNEL)
`define CNN_CONV_SIZE (`CNN_IMG_SIZE - `CNN_KERNEL + 1)  // Valid convolution, no padding
`define CNN_POOL_SIZE (`CNN_CONV_SIZE / 2)

// Feature maps computed side by side
`define CNN_LANES     4

// Fixed point scaling applied after the bias
`define CNN_SHIFT     7

// Data widths
`define CNN_PIXEL_W   8
`define CNN_WEIGHT_W  8
`define CNN_ACC_W     24

`endif

// File: conv/conv_lane.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module conv_lane
    import cnn_pkg::*;
#(
    parameter int LANE_ID = 0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        coef_valid,
    input  lane_t       coef_lane,
    input  coef_index_t coef_index,
    input  weight_t     coef_data,
    input  logic        win_valid,
    input  window_t     window,
    output logic        win_ready,
    output logic        conv_valid,
    output pixel_t      conv_data,
    input  logic        conv_ready
);
    localparam acc_t PIXEL_MAX = acc_t'((1 << `CNN_PIXEL_W) - 1);

    weight_t taps [`CNN_TAPS];
    weight_t bias;
    acc_t    acc;
    acc_t    biased;
    acc_t    scaled;
    pixel_t  result;
    logic    load;

    assign win_ready = !conv_valid || conv_ready;
    assign load      = win_valid && win_ready;

    // Coefficient writes addressed to this lane
    always_ff @(posedge clk) begin
        if (coef_valid && (coef_lane == lane_t'(LANE_ID))) begin
            if (coef_index < coef_index_t'(`CNN_TAPS)) begin
                taps[coef_index] <= coef_data;
            end else if (coef_index == coef_index_t'(`CNN_TAPS)) begin
                bias <= coef_data;
            end
        end
    end

    // Multiply-accumulate, bias, rescale and clamp to 0..255
    always_comb begin
        acc = '0;
        for (int t = 0; t < `CNN_TAPS; t++) begin
            acc = acc + acc_t'(signed'({1'b0, window[t]})) * acc_t'(taps[t]);
        end
        biased = acc + (acc_t'(bias) <<< `CNN_SHIFT);  // Bias lines up with the product scale
        scaled = biased >>> `CNN_SHIFT;
        if (scaled < 0) begin
            result = '0;                               // ReLU
        end else if (scaled > PIXEL_MAX) begin
            result = '1;
        end else begin
            result = scaled[`CNN_PIXEL_W-1:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            conv_valid <= 1'b0;
        end else if (load) begin
            conv_valid <= 1'b1;
        end else if (conv_ready) begin
            conv_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            conv_data <= result;
        end
    end

endmodule

// File: conv/window_former.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module window_former
    import cnn_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pixel_valid,
    input  pixel_t                pixel_data,
    output logic                  pixel_ready,
    output logic                  win_valid,
    output window_t               window,
    input  logic [`CNN_LANES-1:0] lane_ready
);
    localparam int KSIZE   = `CNN_KERNEL;
    localparam int COUNT_W = $clog2(`CNN_IMG_SIZE);

    logic [COUNT_W-1:0] col_cnt;
    logic [COUNT_W-1:0] row_cnt;
    pixel_t             line_buf [KSIZE-1][`CNN_IMG_SIZE];  // Entry 0 holds the row above
    pixel_t             new_col [KSIZE];                    // Entry 0 is the top row
    window_t            shift_win;
    window_t            next_win;
    logic               pix_fire;
    logic               win_fire;
    logic               covers;

    // Window only leaves once every lane takes it
    assign win_fire    = win_valid && (&lane_ready);
    assign pixel_ready = !win_valid || (&lane_ready);
    assign pix_fire    = pixel_valid && pixel_ready;

    // Bottom right corner of a full 5x5 window
    assign covers = (row_cnt >= COUNT_W'(KSIZE - 1)) && (col_cnt >= COUNT_W'(KSIZE - 1));

    // Column that ends at the incoming pixel
    always_comb begin
        new_col[KSIZE-1] = pixel_data;
        for (int k = 0; k < KSIZE - 1; k++) begin
            new_col[KSIZE-2-k] = line_buf[k][col_cnt];
        end
    end

    // Oldest column drops out on the left, new one enters on the right
    always_comb begin
        for (int r = 0; r < KSIZE; r++) begin
            for (int c = 0; c < KSIZE - 1; c++) begin
                next_win[r*KSIZE+c] = shift_win[r*KSIZE+c+1];
            end
            next_win[r*KSIZE+KSIZE-1] = new_col[r];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
        end else begin
            if (pix_fire) begin
                if (col_cnt == COUNT_W'(`CNN_IMG_SIZE - 1)) begin
                    col_cnt <= '0;
                    if (row_cnt == COUNT_W'(`CNN_IMG_SIZE - 1)) begin
                        row_cnt <= '0;  // Next image starts
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end

            if (pix_fire && covers) begin
                win_valid <= 1'b1;
            end else if (win_fire) begin
                win_valid <= 1'b0;
            end
        end
    end

    // Line buffers, shift window and output window
    always_ff @(posedge clk) begin
        if (pix_fire) begin
            for (int k = KSIZE - 2; k > 0; k--) begin
                line_buf[k][col_cnt] <= line_buf[k-1][col_cnt];
            end
            line_buf[0][col_cnt] <= pixel_data;
            shift_win            <= next_win;
            if (covers) begin
                window <= next_win;
            end
        end
    end

endmodule

// File: source/cnn_layer1_top.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module cnn_layer1_top
    import cnn_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        pixel_valid,
    input  pixel_t      pixel_data,
    output logic        pixel_ready,
    input  logic        coef_valid,
    input  lane_t       coef_lane,
    input  coef_index_t coef_index,
    input  weight_t     coef_data,
    output logic        out_valid,
    input  logic        out_ready,
    output pixel_t      out_data,
    output lane_t       out_lane,
    output logic        out_last
);
    logic                    win_valid;
    window_t                 window;
    logic [`CNN_LANES-1:0]   lane_ready;
    logic [`CNN_LANES-1:0]   conv_valid;
    pixel_t [`CNN_LANES-1:0] conv_data;
    logic                    conv_ready;  // Shared by all lanes

    window_former i_window_former (
        .clk         (clk),
        .reset       (reset),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data),
        .pixel_ready (pixel_ready),
        .win_valid   (win_valid),
        .window      (window),
        .lane_ready  (lane_ready)
    );

    // One lane per feature map, each with its own kernel
    for (genvar i = 0; i < `CNN_LANES; i++) begin : g_lane
        conv_lane #(
            .LANE_ID (i)
        ) i_conv_lane (
            .clk        (clk),
            .reset      (reset),
            .coef_valid (coef_valid),
            .coef_lane  (coef_lane),
            .coef_index (coef_index),
            .coef_data  (coef_data),
            .win_valid  (win_valid),
            .window     (window),
            .win_ready  (lane_ready[i]),
            .conv_valid (conv_valid[i]),
            .conv_data  (conv_data[i]),
            .conv_ready (conv_ready)
        );
    end

    pool_serializer i_pool_serializer (
        .clk        (clk),
        .reset      (reset),
        .conv_valid (conv_valid),
        .conv_data  (conv_data),
        .conv_ready (conv_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_lane   (out_lane),
        .out_last   (out_last)
    );

endmodule

// File: source/pool_serializer.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module pool_serializer
    import cnn_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`CNN_LANES-1:0]         conv_valid,
    input  pixel_t [`CNN_LANES-1:0]       conv_data,
    output logic                          conv_ready,
    output logic                          out_valid,
    input  logic                          out_ready,
    output pixel_t                        out_data,
    output lane_t                         out_lane,
    output logic                          out_last
);
    localparam int POS_W     = $clog2(`CNN_CONV_SIZE);
    localparam int LANE_LAST = `CNN_LANES - 1;

    logic [POS_W-1:0] col_cnt;
    logic [POS_W-1:0] row_cnt;
    pixel_t           hold [`CNN_LANES];                     // Even column value of a pair
    pixel_t           row_buf [`CNN_LANES][`CNN_POOL_SIZE];  // Pair maxima of the even row
    pixel_t           pooled [`CNN_LANES];
    logic             emitting;
    lane_t            emit_lane;
    logic             pos_last;
    logic             accept;
    logic             pos_done;

    function automatic pixel_t max2(pixel_t a, pixel_t b);
        return (a > b) ? a : b;
    endfunction

    // Lanes run in lockstep, so lane 0 speaks for all of them
    assign conv_ready = !emitting;
    assign accept     = conv_valid[0] && conv_ready;
    assign pos_done   = accept && row_cnt[0] && col_cnt[0];  // Bottom right of a 2x2 block

    assign out_valid = emitting;
    assign out_data  = pooled[emit_lane];
    assign out_lane  = emit_lane;
    assign out_last  = pos_last && (emit_lane == lane_t'(LANE_LAST));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            emitting  <= 1'b0;
            emit_lane <= '0;
            pos_last  <= 1'b0;
        end else begin
            if (accept) begin
                if (col_cnt == POS_W'(`CNN_CONV_SIZE - 1)) begin
                    col_cnt <= '0;
                    if (row_cnt == POS_W'(`CNN_CONV_SIZE - 1)) begin
                        row_cnt <= '0;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end

            if (pos_done) begin
                emitting  <= 1'b1;
                emit_lane <= '0;
                pos_last  <= (row_cnt == POS_W'(`CNN_CONV_SIZE - 1)) &&
                             (col_cnt == POS_W'(`CNN_CONV_SIZE - 1));
            end else if (out_valid && out_ready) begin
                if (emit_lane == lane_t'(LANE_LAST)) begin
                    emitting <= 1'b0;  // Back to taking convolution results
                end else begin
                    emit_lane <= emit_lane + 1'b1;
                end
            end
        end
    end

    // Max pooling datapath, one copy per lane
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int l = 0; l < `CNN_LANES; l++) begin
                if (!col_cnt[0]) begin
                    hold[l] <= conv_data[l];
                end else if (!row_cnt[0]) begin
                    row_buf[l][col_cnt[POS_W-1:1]] <= max2(hold[l], conv_data[l]);
                end else begin
                    pooled[l] <= max2(row_buf[l][col_cnt[POS_W-1:1]],
                                      max2(hold[l], conv_data[l]));
                end
            end
        end
    end

endmodule

// File: test/cnn_layer1_patterns.hex
// Per test: 4 kernel records (byte 0 = tap 0, byte 25 = bias), 12 image rows (byte c = column c),
// 4 expected pooled rows (byte 4*col + lane). Byte 0 is the rightmost byte of each record.
00_40_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_40
0a_00_00_00_00_c0_00_00_00_00_00_00_00_40_00_00_00_00_00_00_00_40_00_00_00_00
06_40_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_80
fd_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01_01
16_14_12_10_0e_0c_0a_08_06_04_02_00
20_1e_1c_1a_18_16_14_12_10_0e_0c_0a
2a_28_26_24_22_20_1e_1c_1a_18_16_14
34_32_30_2e_2c_2a_28_26_24_22_20_1e
3e_3c_3a_38_36_34_32_30_2e_2c_2a_28
48_46_44_42_40_3e_3c_3a_38_36_34_32
52_50_4e_4c_4a_48_46_44_42_40_3e_3c
5c_5a_58_56_54_52_50_4e_4c_4a_48_46
66_64_62_60_5e_5c_5a_58_56_54_52_50
70_6e_6c_6a_68_66_64_62_60_5e_5c_5a
7a_78_76_74_72_70_6e_6c_6a_68_66_64
84_82_80_7e_7c_7a_78_76_74_72_70_6e
06_18_12_30_05_1a_10_2c_04_1c_0e_28_04_1e_0c_24
0a_0e_1c_44_09_10_1a_40_08_12_18_3c_07_14_16_38
0e_04_26_58_0d_06_24_54_0c_08_22_50_0b_0a_20_4c
12_00_30_6c_11_00_2e_68_10_00_2c_64_0f_00_2a_60
64_00_00_00_00_00_00_00_00_00_00_00_00_7f_00_00_00_00_00_00_00_00_00_00_00_00
7f_80_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_80
7f_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff_ff
80_7f_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_7f
0b_0a_09_08_07_06_05_04_03_02_01_00
1f_1e_1d_1c_1b_1a_19_18_17_16_15_14
33_32_31_30_2f_2e_2d_2c_2b_2a_29_28
47_46_45_44_43_42_41_40_3f_3e_3d_3c
5b_5a_59_58_57_56_55_54_53_52_51_50
6f_6e_6d_6c_6b_6a_69_68_67_66_65_64
83_82_81_80_7f_7e_7d_7c_7b_7a_79_78
97_96_95_94_93_92_91_90_8f_8e_8d_8c
ab_aa_a9_a8_a7_a6_a5_a4_a3_a2_a1_a0
bf_be_bd_bc_bb_ba_b9_b8_b7_b6_b5_b4
d3_d2_d1_d0_cf_ce_cd_cc_cb_ca_c9_c8
e7_e6_e5_e4_e3_e2_e1_e0_df_de_dd_dc
08_75_1f_a8_04_76_23_a6_00_76_27_a4_00_76_2b_a2
58_6d_00_d0_54_6e_00_ce_50_6e_00_cc_4c_6e_00_ca
a7_66_00_f7_a3_66_00_f5_9f_66_00_f3_9b_67_00_f1
f7_5e_00_ff_f3_5e_00_ff_ef_5e_00_ff_eb_5f_00_ff

// File: test/tb_cnn_layer1.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module tb_cnn_layer1
    import cnn_pkg::*;
;
    localparam int RECS_PER_TEST = `CNN_LANES + `CNN_IMG_SIZE + `CNN_POOL_SIZE;
    localparam int NUM_RECS      = 2 * RECS_PER_TEST;
    localparam int PIXELS        = `CNN_IMG_SIZE * `CNN_IMG_SIZE;
    localparam int BEATS         = `CNN_POOL_SIZE * `CNN_POOL_SIZE * `CNN_LANES;
    localparam int BEATS_PER_ROW = `CNN_POOL_SIZE * `CNN_LANES;
    localparam int NUM_RUNS      = 4;
    localparam int CYCLE_LIMIT   = 20 * NUM_RUNS * (PIXELS + BEATS);

    logic        clk;
    logic        reset;
    logic        pixel_valid;
    pixel_t      pixel_data;
    logic        pixel_ready;
    logic        coef_valid;
    lane_t       coef_lane;
    coef_index_t coef_index;
    weight_t     coef_data;
    logic        out_valid;
    logic        out_ready;
    pixel_t      out_data;
    lane_t       out_lane;
    logic        out_last;

    logic [255:0] patterns [NUM_RECS];
    int           cycle_count;

    cnn_layer1_top i_cnn_layer1_top (
        .clk         (clk),
        .reset       (reset),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data),
        .pixel_ready (pixel_ready),
        .coef_valid  (coef_valid),
        .coef_lane   (coef_lane),
        .coef_index  (coef_index),
        .coef_data   (coef_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_lane    (out_lane),
        .out_last    (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    // Writes 25 taps and the bias of every lane
    task automatic load_kernels(input int base);
        for (int l = 0; l < `CNN_LANES; l++) begin
            for (int i = 0; i <= `CNN_TAPS; i++) begin
                @(posedge clk);
                coef_valid <= 1'b1;
                coef_lane  <= lane_t'(l);
                coef_index <= coef_index_t'(i);
                coef_data  <= patterns[base+l][8*i+:8];
            end
        end
        @(posedge clk);
        coef_valid <= 1'b0;
    endtask

    task automatic send_image(input int base, input bit gaps);
        int idx;
        idx = 0;
        while (idx < PIXELS) begin
            @(posedge clk);
            if (pixel_valid && pixel_ready) begin
                idx++;
            end
            if (idx == PIXELS) begin
                pixel_valid <= 1'b0;
            end else if (!(pixel_valid && !pixel_ready)) begin  // Not holding a stalled pixel
                if (gaps && ($urandom % 3 == 0)) begin
                    pixel_valid <= 1'b0;
                end else begin
                    pixel_valid <= 1'b1;
                    pixel_data  <= patterns[base+`CNN_LANES+idx/`CNN_IMG_SIZE]
                                           [8*(idx%`CNN_IMG_SIZE)+:8];
                end
            end
        end
    endtask

    task automatic check_beat(input string name, input int base, input int beat);
        pixel_t exp_data;
        exp_data = patterns[base+`CNN_LANES+`CNN_IMG_SIZE+beat/BEATS_PER_ROW]
                           [8*(beat%BEATS_PER_ROW)+:8];
        assert (out_data == exp_data) else begin
            $display("error %s beat %0d data expected %0d actual %0d",
                     name, beat, exp_data, out_data);
            $display("TESTBENCH FAILED");
            $fatal(1, "data mismatch");
        end
        assert (out_lane == lane_t'(beat % `CNN_LANES)) else begin
            $display("error %s beat %0d lane expected %0d actual %0d",
                     name, beat, beat % `CNN_LANES, out_lane);
            $display("TESTBENCH FAILED");
            $fatal(1, "lane mismatch");
        end
        assert (out_last == (beat == BEATS - 1)) else begin
            $display("error %s beat %0d last expected %0d actual %0d",
                     name, beat, beat == BEATS - 1, out_last);
            $display("TESTBENCH FAILED");
            $fatal(1, "last mismatch");
        end
    endtask

    task automatic collect_results(input string name, input int base, input bit stalls);
        int beat;
        beat = 0;
        while (beat < BEATS) begin
            @(posedge clk);
            if (out_valid && out_ready) begin
                check_beat(name, base, beat);
                beat++;
            end
            if (stalls) begin
                out_ready <= ($urandom % 2 == 0);  // Ready about half the time
            end else begin
                out_ready <= 1'b1;
            end
        end
        @(posedge clk);
        out_ready <= 1'b1;
    endtask

    task automatic run_image(input string name, input int base, input bit gaps,
                             input bit stalls);
        fork
            send_image(base, gaps);
            collect_results(name, base, stalls);
        join
    endtask

    initial begin
        void'($urandom(32'hdc71_88f6));
        cycle_count = 0;
        reset       = 1'b1;
        pixel_valid = 1'b0;
        pixel_data  = '0;
        coef_valid  = 1'b0;
        coef_lane   = '0;
        coef_index  = '0;
        coef_data   = '0;
        out_ready   = 1'b1;
        $readmemh("test/cnn_layer1_patterns.hex", patterns);

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        assert (!out_valid && pixel_ready) else begin
            $display("Idle state after reset is wrong: out_valid %0d pixel_ready %0d",
                     out_valid, pixel_ready);
            $display("TESTBENCH FAILED");
            $fatal(1, "reset state");
        end

        load_kernels(0);
        run_image("test1_stream", 0, 1'b0, 1'b0);
        run_image("test1_out_stall", 0, 1'b0, 1'b1);
        run_image("test1_pixel_gaps", 0, 1'b1, 1'b0);

        // New kernels, no reset in between
        load_kernels(RECS_PER_TEST);
        run_image("test2_clamp", RECS_PER_TEST, 1'b0, 1'b0);

        // No stray beats after the last image
        repeat (20) begin
            @(posedge clk);
            assert (!out_valid) else begin
                $display("An extra output beat appeared after the last image");
                $display("TESTBENCH FAILED");
                $fatal(1, "extra beat");
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/cnn_pkg.sv
conv/window_former.sv
conv/conv_lane.sv
source/pool_serializer.sv
source/cnn_layer1_top.sv
test/tb_cnn_layer1.sv
